//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_buffer
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
src/if_pkg.sv
src/fetch_wr_if.sv
src/queue_head_if.sv
src/inst_fifo.sv
src/issue_ctrl.sv
src/fetch_buffer_top.sv
test/fetch_buffer_checker.sv
test/tb_fetch_buffer.sv

//--- src/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top #(
    parameter int fifo_depth = 16
) (
    input  logic                      clk,
    input  logic                      fifo_rst,
    input  logic                      flush,
    input  logic                      write_en1,
    input  logic                      write_en2,
    input  logic [if_pkg::word_w-1:0] write_data1,
    input  logic [if_pkg::word_w-1:0] write_data2,
    input  logic [if_pkg::word_w-1:0] write_addr1,
    input  logic [if_pkg::word_w-1:0] write_addr2,
    input  logic [if_pkg::exc_w-1:0]  write_exc,
    input  logic                      decode_ready,
    output logic                      full,
    output logic                      issue_valid1,
    output logic                      issue_valid2,
    output logic [if_pkg::word_w-1:0] issue_inst1,
    output logic [if_pkg::word_w-1:0] issue_inst2,
    output logic [if_pkg::word_w-1:0] issue_pc1,
    output logic [if_pkg::word_w-1:0] issue_pc2,
    output logic [if_pkg::exc_w-1:0]  issue_exc1,
    output logic [if_pkg::exc_w-1:0]  issue_exc2,
    output logic                      in_delay_slot,
    output logic [if_pkg::cnt_w-1:0]  master_count,
    output logic [if_pkg::cnt_w-1:0]  slave_count
);

    fetch_wr_if   u_wr_if ();
    queue_head_if u_head_if ();

    // fetch pins onto the write bundle
    assign u_wr_if.wr_en1   = write_en1;
    assign u_wr_if.wr_en2   = write_en2;
    assign u_wr_if.wr_data1 = write_data1;
    assign u_wr_if.wr_data2 = write_data2;
    assign u_wr_if.wr_addr1 = write_addr1;
    assign u_wr_if.wr_addr2 = write_addr2;
    assign u_wr_if.wr_exc   = write_exc;

    inst_fifo #(
        .fifo_depth (fifo_depth)
    ) u_inst_fifo (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .flush    (flush),
        .wr       (u_wr_if.dst),
        .head     (u_head_if.fifo),
        .full     (full)
    );

    issue_ctrl u_issue_ctrl (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .decode_ready  (decode_ready),
        .head          (u_head_if.issue),
        .issue_valid1  (issue_valid1),
        .issue_valid2  (issue_valid2),
        .issue_inst1   (issue_inst1),
        .issue_inst2   (issue_inst2),
        .issue_pc1     (issue_pc1),
        .issue_pc2     (issue_pc2),
        .issue_exc1    (issue_exc1),
        .issue_exc2    (issue_exc2),
        .in_delay_slot (in_delay_slot),
        .master_count  (master_count),
        .slave_count   (slave_count)
    );

endmodule

//--- src/fetch_wr_if.sv
`timescale 1ns/1ps

interface fetch_wr_if;
    import if_pkg::*;

    // second word only together with the first
    logic              wr_en1;
    logic              wr_en2;
    logic [word_w-1:0] wr_data1;
    logic [word_w-1:0] wr_data2;
    // pc of each word
    logic [word_w-1:0] wr_addr1;
    logic [word_w-1:0] wr_addr2;
    // one code for the whole fetch pair
    logic [exc_w-1:0]  wr_exc;

    modport src (
        output wr_en1, wr_en2,
        output wr_data1, wr_data2,
        output wr_addr1, wr_addr2,
        output wr_exc
    );

    modport dst (
        input wr_en1, wr_en2,
        input wr_data1, wr_data2,
        input wr_addr1, wr_addr2,
        input wr_exc
    );

endinterface

//--- src/if_pkg.sv
package if_pkg;

    // datapath widths
    localparam int word_w = 32;
    localparam int exc_w  = 12;
    localparam int cnt_w  = 64;

    // one instruction word, seen as R-format or as I-format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
    } inst_word_u;

    // primary opcodes of the control-transfer group
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_regimm  = 6'b000001;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;

    // register jumps under op_special
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_jalr = 6'b001001;

endpackage

//--- src/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic       clk,
    input  logic       fifo_rst,
    input  logic       flush,
    fetch_wr_if.dst    wr,
    queue_head_if.fifo head,
    output logic       full
);
    import if_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    // payload arrays, one slot per instruction
    logic [word_w-1:0] data_mem [fifo_depth];
    logic [word_w-1:0] addr_mem [fifo_depth];
    logic [exc_w-1:0]  exc_mem  [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr_p1;
    logic [ptr_w-1:0] rd_ptr_p1;
    // occupancy, one bit wider than the pointers
    logic [ptr_w:0]   occ;
    logic [1:0]       wr_num;
    logic [1:0]       rd_num;

    // depth has to wrap the pointers cleanly
    if (fifo_depth < 4 || (fifo_depth & (fifo_depth - 1)) != 0) begin : g_bad_depth
        $error("inst_fifo: fifo_depth must be a power of two, at least 4");
    end

    // second slot wraps with the pointer width
    assign wr_ptr_p1 = wr_ptr + ptr_w'(1);
    assign rd_ptr_p1 = rd_ptr + ptr_w'(1);

    // entries moved this cycle
    assign wr_num = {1'b0, wr.wr_en1} + {1'b0, wr.wr_en2};
    assign rd_num = {1'b0, head.rd_en1} + {1'b0, head.rd_en2};

    // status straight from the count
    assign head.empty        = (occ == '0);
    assign head.almost_empty = (occ == (ptr_w + 1)'(1));
    // fewer than two free slots
    assign full = (occ >= (ptr_w + 1)'(fifo_depth - 1));

    // store path, dropped on flush
    always_ff @(posedge clk) begin
        if (!flush && wr.wr_en1) begin
            data_mem[wr_ptr] <= wr.wr_data1;
            addr_mem[wr_ptr] <= wr.wr_addr1;
            exc_mem[wr_ptr]  <= wr.wr_exc;
        end
        if (!flush && wr.wr_en2) begin
            data_mem[wr_ptr_p1] <= wr.wr_data2;
            addr_mem[wr_ptr_p1] <= wr.wr_addr2;
            // pair shares the first word's code
            exc_mem[wr_ptr_p1]  <= wr.wr_exc;
        end
    end

    // pointers and count; flush only rewinds, storage untouched
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_w'(wr_num);
            rd_ptr <= rd_ptr + ptr_w'(rd_num);
            occ    <= occ + (ptr_w + 1)'(wr_num) - (ptr_w + 1)'(rd_num);
        end
    end

    // head view, invalid slots forced to zero
    always_comb begin
        head.head_data1 = '0;
        head.head_addr1 = '0;
        head.head_exc1  = '0;
        head.head_data2 = '0;
        head.head_addr2 = '0;
        head.head_exc2  = '0;
        if (!head.empty) begin
            head.head_data1 = data_mem[rd_ptr];
            head.head_addr1 = addr_mem[rd_ptr];
            head.head_exc1  = exc_mem[rd_ptr];
        end
        // two or more queued
        if (!head.empty && !head.almost_empty) begin
            head.head_data2 = data_mem[rd_ptr_p1];
            head.head_addr2 = addr_mem[rd_ptr_p1];
            head.head_exc2  = exc_mem[rd_ptr_p1];
        end
    end

    // fetch must hold off once full
    a_no_wr_full: assert property (@(posedge clk) disable iff (fifo_rst)
        full |-> !wr.wr_en1)
        else $error("inst_fifo: write while full");

    a_wr_pair: assert property (@(posedge clk) disable iff (fifo_rst)
        wr.wr_en2 |-> wr.wr_en1)
        else $error("inst_fifo: wr_en2 without wr_en1");

    // issue side never pops more than is queued
    a_rd_occ: assert property (@(posedge clk) disable iff (fifo_rst)
        (ptr_w + 1)'(rd_num) <= occ)
        else $error("inst_fifo: read past occupancy");

endmodule

//--- src/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                      clk,
    input  logic                      fifo_rst,
    input  logic                      decode_ready,
    queue_head_if.issue               head,
    output logic                      issue_valid1,
    output logic                      issue_valid2,
    output logic [if_pkg::word_w-1:0] issue_inst1,
    output logic [if_pkg::word_w-1:0] issue_inst2,
    output logic [if_pkg::word_w-1:0] issue_pc1,
    output logic [if_pkg::word_w-1:0] issue_pc2,
    output logic [if_pkg::exc_w-1:0]  issue_exc1,
    output logic [if_pkg::exc_w-1:0]  issue_exc2,
    output logic                      in_delay_slot,
    output logic [if_pkg::cnt_w-1:0]  master_count,
    output logic [if_pkg::cnt_w-1:0]  slave_count
);
    import if_pkg::*;

    inst_word_u word1;
    inst_word_u word2;
    logic       br1;
    logic       br2;

    // any branch or jump with or without link
    function automatic logic is_branch(input inst_word_u w);
        logic hit;
        hit = 1'b0;
        case (w.i_fmt.opcode)
            op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz: hit = 1'b1;
            // jr / jalr sit in the funct field
            op_special: hit = (w.r_fmt.funct == fn_jr) || (w.r_fmt.funct == fn_jalr);
            // only bltz bgez bltzal bgezal by their rt code
            op_regimm: hit = (w.i_fmt.rt[3:1] == 3'b000);
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    assign word1 = head.head_data1;
    assign word2 = head.head_data2;
    assign br1   = is_branch(word1);
    assign br2   = is_branch(word2);

    // master needs one entry and a ready decode
    assign issue_valid1 = !head.empty && decode_ready;
    // slave needs a second entry and must not be a branch
    assign issue_valid2 = issue_valid1 && !head.almost_empty && !br2;

    // pop what was issued
    assign head.rd_en1 = issue_valid1;
    assign head.rd_en2 = issue_valid2;

    // payload zero unless valid
    assign issue_inst1 = issue_valid1 ? head.head_data1 : '0;
    assign issue_pc1   = issue_valid1 ? head.head_addr1 : '0;
    assign issue_exc1  = issue_valid1 ? head.head_exc1  : '0;
    assign issue_inst2 = issue_valid2 ? head.head_data2 : '0;
    assign issue_pc2   = issue_valid2 ? head.head_addr2 : '0;
    assign issue_exc2  = issue_valid2 ? head.head_exc2  : '0;

    // a lone master branch makes the next master its delay slot
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            in_delay_slot <= 1'b0;
        end else begin
            in_delay_slot <= issue_valid1 && br1 && !issue_valid2;
        end
    end

    // retired-issue counters
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            master_count <= '0;
            slave_count  <= '0;
        end else begin
            master_count <= master_count + cnt_w'(issue_valid1);
            slave_count  <= slave_count + cnt_w'(issue_valid2);
        end
    end

endmodule

//--- src/queue_head_if.sv
`timescale 1ns/1ps

interface queue_head_if;
    import if_pkg::*;

    // two oldest entries, zero when not valid
    logic [word_w-1:0] head_data1;
    logic [word_w-1:0] head_data2;
    logic [word_w-1:0] head_addr1;
    logic [word_w-1:0] head_addr2;
    logic [exc_w-1:0]  head_exc1;
    logic [exc_w-1:0]  head_exc2;
    // occupancy levels
    logic              empty;
    logic              almost_empty;
    // pop strobes back from issue
    logic              rd_en1;
    logic              rd_en2;

    modport fifo (
        output head_data1, head_data2, head_addr1, head_addr2,
        output head_exc1, head_exc2, empty, almost_empty,
        input  rd_en1, rd_en2
    );

    modport issue (
        input  head_data1, head_data2, head_addr1, head_addr2,
        input  head_exc1, head_exc2, empty, almost_empty,
        output rd_en1, rd_en2
    );

endinterface

//--- test/fetch_buffer_checker.sv
`timescale 1ns/1ps

module fetch_buffer_checker #(
    parameter int fifo_depth = 16
) (
    input  logic                      clk,
    input  logic                      fifo_rst,
    input  logic                      flush,
    input  logic                      write_en1,
    input  logic                      write_en2,
    input  logic [if_pkg::word_w-1:0] write_data1,
    input  logic [if_pkg::word_w-1:0] write_data2,
    input  logic [if_pkg::word_w-1:0] write_addr1,
    input  logic [if_pkg::word_w-1:0] write_addr2,
    input  logic [if_pkg::exc_w-1:0]  write_exc,
    input  logic                      decode_ready,
    input  logic                      full,
    input  logic                      issue_valid1,
    input  logic                      issue_valid2,
    input  logic [if_pkg::word_w-1:0] issue_inst1,
    input  logic [if_pkg::word_w-1:0] issue_inst2,
    input  logic [if_pkg::word_w-1:0] issue_pc1,
    input  logic [if_pkg::word_w-1:0] issue_pc2,
    input  logic [if_pkg::exc_w-1:0]  issue_exc1,
    input  logic [if_pkg::exc_w-1:0]  issue_exc2,
    input  logic                      in_delay_slot,
    input  logic [if_pkg::cnt_w-1:0]  master_count,
    input  logic [if_pkg::cnt_w-1:0]  slave_count,
    output int                        err_count
);
    import if_pkg::*;

    // one cycle's expected issue bundle
    typedef struct packed {
        logic              v1;
        logic              v2;
        logic [word_w-1:0] i1;
        logic [word_w-1:0] i2;
        logic [word_w-1:0] p1;
        logic [word_w-1:0] p2;
        logic [exc_w-1:0]  e1;
        logic [exc_w-1:0]  e2;
    } issue_t;

    // model queue, oldest entry at index 0
    logic [word_w-1:0] q_data[$];
    logic [word_w-1:0] q_pc[$];
    logic [exc_w-1:0]  q_exc[$];
    logic              m_ds;
    logic [cnt_w-1:0]  m_master;
    logic [cnt_w-1:0]  m_slave;

    // mips control transfers: j..bgtz, jr/jalr, bltz/bgez(al)
    function automatic logic branch_word(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op >= 6'd2 && op <= 6'd7) begin
            return 1'b1;
        end
        if (op == 6'd0) begin
            return w[5:0] == 6'h08 || w[5:0] == 6'h09;
        end
        if (op == 6'd1) begin
            return w[20:16] inside {5'd0, 5'd1, 5'd16, 5'd17};
        end
        return 1'b0;
    endfunction

    // expected issue from head entries and decode_ready
    function automatic issue_t ref_issue(
        input int                n,
        input logic              rdy,
        input logic [word_w-1:0] d1,
        input logic [word_w-1:0] d2,
        input logic [word_w-1:0] pc1,
        input logic [word_w-1:0] pc2,
        input logic [exc_w-1:0]  x1,
        input logic [exc_w-1:0]  x2
    );
        issue_t r;
        r.v1 = (n > 0) && rdy;
        // slave slot never takes a branch
        r.v2 = r.v1 && (n > 1) && !branch_word(d2);
        r.i1 = r.v1 ? d1 : '0;
        r.p1 = r.v1 ? pc1 : '0;
        r.e1 = r.v1 ? x1 : '0;
        r.i2 = r.v2 ? d2 : '0;
        r.p2 = r.v2 ? pc2 : '0;
        r.e2 = r.v2 ? x2 : '0;
        return r;
    endfunction

    function automatic issue_t model_issue(input logic rdy);
        int n;
        n = q_data.size();
        return ref_issue(n, rdy,
                         n > 0 ? q_data[0] : '0, n > 1 ? q_data[1] : '0,
                         n > 0 ? q_pc[0] : '0, n > 1 ? q_pc[1] : '0,
                         n > 0 ? q_exc[0] : '0, n > 1 ? q_exc[1] : '0);
    endfunction

    task automatic clear_model();
        q_data.delete();
        q_pc.delete();
        q_exc.delete();
    endtask

    task automatic pop_entry();
        void'(q_data.pop_front());
        void'(q_pc.pop_front());
        void'(q_exc.pop_front());
    endtask

    task automatic push_entry(input logic [word_w-1:0] d, input logic [word_w-1:0] pc);
        q_data.push_back(d);
        q_pc.push_back(pc);
        // both words of a pair carry the same code
        q_exc.push_back(write_exc);
    endtask

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            err_count++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // model follows the edge, inputs stable since the falling edge
    always @(posedge clk) begin
        issue_t e;
        e = model_issue(decode_ready);
        if (fifo_rst) begin
            clear_model();
            m_ds = 1'b0;
            m_master = '0;
            m_slave = '0;
        end else begin
            // issue in a flush cycle still counts
            m_ds = e.v1 && branch_word(e.i1) && !e.v2;
            m_master = m_master + cnt_w'(e.v1);
            m_slave = m_slave + cnt_w'(e.v2);
            if (flush) begin
                clear_model();
            end else begin
                if (e.v1) begin
                    pop_entry();
                end
                if (e.v2) begin
                    pop_entry();
                end
                if (write_en1) begin
                    push_entry(write_data1, write_addr1);
                end
                if (write_en2) begin
                    push_entry(write_data2, write_addr2);
                end
            end
        end
    end

    // outputs settled half a cycle after the edge
    always @(negedge clk) begin
        issue_t e;
        if (fifo_rst) begin
            err_count = 0;
        end else begin
            e = model_issue(decode_ready);
            compare("issue_valid1", 64'(issue_valid1), 64'(e.v1));
            compare("issue_valid2", 64'(issue_valid2), 64'(e.v2));
            compare("issue_inst1", 64'(issue_inst1), 64'(e.i1));
            compare("issue_inst2", 64'(issue_inst2), 64'(e.i2));
            compare("issue_pc1", 64'(issue_pc1), 64'(e.p1));
            compare("issue_pc2", 64'(issue_pc2), 64'(e.p2));
            compare("issue_exc1", 64'(issue_exc1), 64'(e.e1));
            compare("issue_exc2", 64'(issue_exc2), 64'(e.e2));
            // fewer than two free entries
            compare("full", 64'(full), 64'(q_data.size() >= fifo_depth - 1));
            compare("in_delay_slot", 64'(in_delay_slot), 64'(m_ds));
            compare("master_count", master_count, m_master);
            compare("slave_count", slave_count, m_slave);
            if (issue_valid2 && branch_word(issue_inst2)) begin
                err_count++;
                $display("** Error at %0t: branch %0h issued in slave slot", $time, issue_inst2);
            end
        end
    end

endmodule

//--- test/tb_fetch_buffer.sv
`timescale 1ns/1ps

module tb_fetch_buffer;
    import if_pkg::*;

    localparam int fifo_depth = 16;

    // phase lengths in cycles
    localparam int len_single = 200;
    localparam int len_dual   = 600;
    localparam int len_branch = 400;
    localparam int len_bp     = 400;
    localparam int len_flush  = 400;
    localparam int len_drain  = 60;
    localparam int run_cycles = len_single + len_dual + len_branch + len_bp + len_flush + len_drain;
    // reset plus some slack
    localparam int cycle_limit = run_cycles + 8 + 50;

    logic              clk = 1'b0;
    logic              fifo_rst;
    logic              flush;
    logic              write_en1;
    logic              write_en2;
    logic [word_w-1:0] write_data1;
    logic [word_w-1:0] write_data2;
    logic [word_w-1:0] write_addr1;
    logic [word_w-1:0] write_addr2;
    logic [exc_w-1:0]  write_exc;
    logic              decode_ready;
    logic              full;
    logic              issue_valid1;
    logic              issue_valid2;
    logic [word_w-1:0] issue_inst1;
    logic [word_w-1:0] issue_inst2;
    logic [word_w-1:0] issue_pc1;
    logic [word_w-1:0] issue_pc2;
    logic [exc_w-1:0]  issue_exc1;
    logic [exc_w-1:0]  issue_exc2;
    logic              in_delay_slot;
    logic [cnt_w-1:0]  master_count;
    logic [cnt_w-1:0]  slave_count;
    int                err_count;

    int                cycle_cnt = 0;
    int                phases_run = 0;
    int                phases_failed = 0;
    logic [31:0]       lfsr_state;
    logic [word_w-1:0] next_pc;

    fetch_buffer_top #(.fifo_depth(fifo_depth)) u_dut (.*);

    fetch_buffer_checker #(.fifo_depth(fifo_depth)) u_chk (.*);

    always #4 clk = ~clk;

    // hard stop on a stuck run
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // branch with odds br_th/16, else a plain alu or memory word
    task automatic make_word(input int br_th, output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] sel;
        take_bits(4, sel);
        take_bits(26, r);
        if (sel < br_th) begin
            take_bits(3, sel);
            case (sel)
                0: w = {6'h00, r[25:6], 6'h08};
                1: w = {6'h00, r[25:6], 6'h09};
                // regimm, rt one of bltz bgez bltzal bgezal
                2: w = {6'h01, r[25:21], r[20], 3'b000, r[16], r[15:0]};
                3: w = {6'h02, r[25:0]};
                default: w = {3'b000, sel[2:0], r[25:0]};
            endcase
        end else begin
            take_bits(1, sel);
            // special funct 0x20..0x2f, or opcode 32..63
            w = sel[0] ? {6'h00, r[25:6], 2'b10, r[3:0]} : {1'b1, r[4:0], r[25:0]};
        end
    endtask

    task automatic drive_cycle(input int wr_th, input int rdy_th, input int br_th,
                               input int fl_th, input bit single);
        logic [31:0] r;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] ex;
        logic        en1;
        logic        en2;
        @(negedge clk);
        take_bits(4, r);
        // fetch stalls on full
        en1 = !full && (r < wr_th);
        take_bits(1, r);
        en2 = en1 && !single && r[0];
        make_word(br_th, w1);
        make_word(br_th, w2);
        take_bits(3, r);
        take_bits(12, ex);
        // exception code on about one pair in eight
        if (r != 0) begin
            ex = '0;
        end
        write_en1 <= en1;
        write_en2 <= en2;
        write_data1 <= w1;
        write_data2 <= w2;
        write_addr1 <= next_pc;
        write_addr2 <= next_pc + 4;
        write_exc <= ex[exc_w-1:0];
        take_bits(4, r);
        decode_ready <= (r < rdy_th);
        take_bits(6, r);
        flush <= (r < fl_th);
        if (en1) begin
            next_pc = next_pc + (en2 ? 8 : 4);
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input int wr_th,
                             input int rdy_th, input int br_th, input int fl_th,
                             input bit single);
        int errs_before;
        errs_before = err_count;
        repeat (cycles) begin
            drive_cycle(wr_th, rdy_th, br_th, fl_th, single);
        end
        phases_run++;
        if (err_count == errs_before) begin
            $display("phase %-14s %4d cycles  ok", name, cycles);
        end else begin
            phases_failed++;
            $display("phase %-14s %4d cycles  %0d errors", name, cycles, err_count - errs_before);
        end
    endtask

    initial begin
        fifo_rst = 1'b1;
        flush = 1'b0;
        write_en1 = 1'b0;
        write_en2 = 1'b0;
        write_data1 = '0;
        write_data2 = '0;
        write_addr1 = '0;
        write_addr2 = '0;
        write_exc = '0;
        decode_ready = 1'b0;
        lfsr_state = 32'h6339_ee70;
        next_pc = 32'h0040_0000;
        repeat (8) @(negedge clk);
        fifo_rst <= 1'b0;

        // name, cycles, write, ready, branch odds of 16; flush odds of 64
        run_phase("single entry", len_single, 4, 16, 4, 0, 1'b1);
        run_phase("dual issue", len_dual, 10, 12, 3, 0, 1'b0);
        run_phase("branch heavy", len_branch, 12, 12, 8, 0, 1'b0);
        run_phase("back-pressure", len_bp, 14, 3, 3, 0, 1'b0);
        run_phase("flush", len_flush, 12, 10, 4, 4, 1'b0);
        run_phase("drain", len_drain, 0, 16, 0, 0, 1'b0);

        $display("phases %0d, passed %0d, failed %0d, errors %0d, issued %0d master %0d slave",
                 phases_run, phases_run - phases_failed, phases_failed, err_count,
                 master_count, slave_count);
        if (phases_failed == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
